/* eth_pkg.sv */
`default_nettype none

package eth_pkg;

    // ####################
    // Width types.
    typedef logic [7:0]  byte_t;
    typedef logic [11:0] ram_addr_t;   // 4096 payload bytes.
    typedef logic [15:0] len_t;
    typedef logic [10:0] buf_addr_t;

    // ####################
    // Bus and beat structs.
    typedef struct packed {
        logic      cyc;
        logic      stb;
        ram_addr_t adr;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        byte_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  calc;     // Byte covered by the CRC.
        logic  last;     // Final byte before the FCS.
        byte_t data;
    } frame_beat_t;

    // ####################
    // Frame constants.
    localparam len_t        PKT_MAX_LEN  = 16'd1400;
    localparam len_t        MIN_PAYLOAD  = 16'd18;   // Ethernet payload reaches 46.
    localparam logic [47:0] SRC_MAC      = 48'h00_0A_35_01_FE_C0;
    localparam logic [47:0] DST_MAC      = 48'h00_0A_35_01_FE_D2;
    localparam logic [31:0] SRC_IP       = 32'hC0_A8_16_C8;
    localparam logic [31:0] DST_IP       = 32'hC0_A8_16_64;
    localparam logic [15:0] UDP_SRC_PORT = 16'h1F90;
    localparam logic [15:0] UDP_DST_PORT = 16'h1F90;
    localparam byte_t       IP_TTL       = 8'h80;
    localparam int          IFG_CYCLES   = 12;

endpackage

`default_nettype wire

/* eth_tx_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_tx_assert (
    input wire                       gmii_tx_clk,
    input wire                       rst,
    input wire                       stb_i,
    input wire                       ack_i,
    input wire eth_pkg::frame_beat_t beat_i,
    input wire                       pkt_req_i,
    input wire                       busy_i
);

    // Ack only in the cycle after a strobe.
    ack_after_stb: assert property (@(posedge gmii_tx_clk) disable iff (rst)
        ack_i |-> $past(stb_i))
        else $error("Wishbone ack without a strobe in the cycle before");

    beat_contiguous: assert property (@(posedge gmii_tx_clk) disable iff (rst)
        beat_i.valid && !beat_i.last |=> beat_i.valid)
        else $error("beat valid fell inside a frame");

    req_when_idle: assert property (@(posedge gmii_tx_clk) disable iff (rst)
        pkt_req_i |-> !busy_i)
        else $error("pkt_req raised while a frame is active");

endmodule

bind tx_segmenter eth_tx_assert i_seg_assert (
    .gmii_tx_clk (gmii_tx_clk),
    .rst         (rst),
    .stb_i       (wb_req_o.stb),
    .ack_i       (wb_rsp_i.ack),
    .beat_i      ('0),
    .pkt_req_i   (1'b0),
    .busy_i      (1'b0)
);

bind udp_framer eth_tx_assert i_frm_assert (
    .gmii_tx_clk (gmii_tx_clk),
    .rst         (rst),
    .stb_i       (1'b0),
    .ack_i       (1'b0),
    .beat_i      (beat_o),
    .pkt_req_i   (pkt_req_i),
    .busy_i      (state != IDLE)
);

`default_nettype wire

/* eth_tx_top.f */
eth_pkg.sv
payload_ram.sv
tx_segmenter.sv
udp_framer.sv
gmii_fcs_tx.sv
eth_tx_top.sv
eth_tx_assert.sv
tb_eth_tx.sv

/* eth_tx_top.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_tx_top (
    input  wire                     gmii_tx_clk,
    input  wire                     rst,
    input  wire                     send_i,
    input  wire eth_pkg::len_t      tx_len_i,
    input  wire eth_pkg::ram_addr_t tx_addr_i,
    output logic                    done_o,
    input  wire                     host_we_i,
    input  wire eth_pkg::ram_addr_t host_addr_i,
    input  wire eth_pkg::byte_t     host_data_i,
    output logic                    gmii_tx_en_o,
    output eth_pkg::byte_t          gmii_txd_o
);
    import eth_pkg::*;

    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        pkt_req;
    len_t        pkt_len;
    logic        wr_en;
    byte_t       wr_data;
    logic        pkt_end;
    frame_beat_t beat;

    payload_ram i_payload_ram (
        .gmii_tx_clk (gmii_tx_clk),
        .rst         (rst),
        .host_we_i   (host_we_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp)
    );

    tx_segmenter i_tx_segmenter (
        .gmii_tx_clk (gmii_tx_clk),
        .rst         (rst),
        .send_i      (send_i),
        .tx_len_i    (tx_len_i),
        .tx_addr_i   (tx_addr_i),
        .done_o      (done_o),
        .wb_req_o    (wb_req),
        .wb_rsp_i    (wb_rsp),
        .pkt_req_o   (pkt_req),
        .pkt_len_o   (pkt_len),
        .wr_en_o     (wr_en),
        .wr_data_o   (wr_data),
        .pkt_end_i   (pkt_end)
    );

    udp_framer i_udp_framer (
        .gmii_tx_clk (gmii_tx_clk),
        .rst         (rst),
        .pkt_req_i   (pkt_req),
        .pkt_len_i   (pkt_len),
        .wr_en_i     (wr_en),
        .wr_data_i   (wr_data),
        .pkt_end_o   (pkt_end),
        .beat_o      (beat)
    );

    gmii_fcs_tx i_gmii_fcs_tx (
        .gmii_tx_clk  (gmii_tx_clk),
        .rst          (rst),
        .beat_i       (beat),
        .gmii_tx_en_o (gmii_tx_en_o),
        .gmii_txd_o   (gmii_txd_o)
    );

endmodule

`default_nettype wire

/* gmii_fcs_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module gmii_fcs_tx (
    input  wire                       gmii_tx_clk,
    input  wire                       rst,
    input  wire eth_pkg::frame_beat_t beat_i,
    output logic                      gmii_tx_en_o,
    output eth_pkg::byte_t            gmii_txd_o
);
    import eth_pkg::*;

    logic [31:0] crc;
    logic [1:0]  fcs_cnt;
    logic        fcs_active;

    // Reflected CRC-32, one byte per step.
    function automatic logic [31:0] crc32_step(input logic [31:0] c_in, input byte_t d);
        logic [31:0] c;
        c = c_in ^ {24'h000000, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge gmii_tx_clk or posedge rst) begin
        if (rst) begin
            crc          <= '1;
            fcs_cnt      <= '0;
            fcs_active   <= 1'b0;
            gmii_tx_en_o <= 1'b0;
            gmii_txd_o   <= '0;
        end else if (beat_i.valid) begin
            gmii_tx_en_o <= 1'b1;
            gmii_txd_o   <= beat_i.data;
            crc          <= beat_i.calc ? crc32_step(crc, beat_i.data) : '1;   // Preamble reseeds.
            fcs_active   <= beat_i.last;
            fcs_cnt      <= '0;
        end else if (fcs_active) begin
            // FCS, least significant byte first.
            gmii_tx_en_o <= 1'b1;
            gmii_txd_o   <= ~crc[7:0];
            crc          <= {8'hFF, crc[31:8]};
            fcs_cnt      <= fcs_cnt + 1'b1;
            fcs_active   <= (fcs_cnt != 2'd3);
        end else begin
            gmii_tx_en_o <= 1'b0;
            gmii_txd_o   <= '0;
        end
    end

endmodule

`default_nettype wire

/* payload_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module payload_ram (
    input  wire                     gmii_tx_clk,
    input  wire                     rst,
    input  wire                     host_we_i,
    input  wire eth_pkg::ram_addr_t host_addr_i,
    input  wire eth_pkg::byte_t     host_data_i,
    input  wire eth_pkg::wb_req_t   wb_req_i,
    output eth_pkg::wb_rsp_t        wb_rsp_o
);
    import eth_pkg::*;

    byte_t mem [2**$bits(ram_addr_t)];
    byte_t dat_q;
    logic  ack_q;

    always_ff @(posedge gmii_tx_clk) begin
        if (host_we_i) begin
            mem[host_addr_i] <= host_data_i;
        end
        if (wb_req_i.cyc && wb_req_i.stb) begin
            dat_q <= mem[wb_req_i.adr];   // Read data travels with the ack.
        end
    end

    // One ack per strobe, dropped again with stb.
    always_ff @(posedge gmii_tx_clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_req_i.cyc && wb_req_i.stb && !ack_q;
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Ethernet transmit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_tx \
    -f eth_tx_top.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_eth_tx > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Result: PASS"
exit 0

/* tb_eth_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_eth_tx;
    import eth_pkg::*;

    logic        gmii_tx_clk = 1'b0;
    logic        rst;
    logic        send_i;
    len_t        tx_len_i;
    ram_addr_t   tx_addr_i;
    logic        done_o;
    logic        host_we_i;
    ram_addr_t   host_addr_i;
    byte_t       host_data_i;
    logic        gmii_tx_en_o;
    byte_t       gmii_txd_o;

    byte_t       model_mem [2**$bits(ram_addr_t)];
    byte_t       exp_q [$];
    byte_t       got_q [$];
    len_t        lens [6];
    ram_addr_t   addrs [6];
    logic [31:0] lfsr = 32'h35681048;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit;

    always #5 gmii_tx_clk = ~gmii_tx_clk;

    eth_tx_top i_dut (.*);

    // ####################
    // Helpers.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // Taps 32,22,2,1.
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // CRC-32 in MSB-first register form with data bits fed LSB first.
    function automatic logic [31:0] crc32_msb_step(input logic [31:0] c_in, input byte_t d);
        logic [31:0] c;
        logic        fb;
        c = c_in;
        for (int j = 0; j < 8; j++) begin
            fb = c[31] ^ d[j];
            c  = {c[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
        end
        return c;
    endfunction

    function automatic len_t packet_count(input len_t len);
        return len_t'((int'(len) + int'(PKT_MAX_LEN) - 1) / int'(PKT_MAX_LEN));
    endfunction

    task automatic abort_run(input string why);
        $display("%0d ns: %s", $time, why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_byte(input byte_t got, input byte_t expected, input string what);
        if (got !== expected) begin
            $display("Fail %0d ns: %s is %h, expected %h", $time, what, got, expected);
            $display("Something failed");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_len(input len_t got, input len_t expected, input string what);
        if (got !== expected) begin
            $display("Fail %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Something failed");
            $fatal(1, "length mismatch");
        end
    endtask

    // ####################
    // Reference frame.
    task automatic build_frame(input len_t plen, input ram_addr_t base);
        logic [159:0] ip;
        logic [335:0] hdr;
        logic [31:0]  sum;
        logic [31:0]  crc;
        byte_t        fcs;
        int           n;
        ip = {8'h45, 8'h00, plen + 16'd28, 32'h0000_4000, IP_TTL, 8'h11, 16'h0000,
              SRC_IP, DST_IP};
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {16'h0000, ip[159 - 16 * i -: 16]};
        end
        while (sum[31:16] != '0) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        ip[79:64] = ~sum[15:0];   // Header checksum field.
        hdr = {DST_MAC, SRC_MAC, 16'h0800, ip, UDP_SRC_PORT, UDP_DST_PORT,
               plen + 16'd8, 16'h0000};
        exp_q.delete();
        for (int i = 0; i < 8; i++) begin
            exp_q.push_back(i == 7 ? 8'hD5 : 8'h55);
        end
        for (int i = 0; i < 42; i++) begin
            exp_q.push_back(hdr[335 - 8 * i -: 8]);
        end
        for (int i = 0; i < int'(MIN_PAYLOAD) || i < int'(plen); i++) begin
            exp_q.push_back(i < int'(plen) ? model_mem[ram_addr_t'(base + i)] : 8'h00);
        end
        crc = '1;
        n   = exp_q.size();
        for (int i = 8; i < n; i++) begin
            crc = crc32_msb_step(crc, exp_q[i]);
        end
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 8; j++) begin
                fcs[j] = ~crc[31 - 8 * k - j];   // x^31 goes out first.
            end
            exp_q.push_back(fcs);
        end
    endtask

    // ####################
    // Host side and GMII capture.
    task automatic fill_ram();
        byte_t d;
        for (int a = 0; a < $size(model_mem); a++) begin
            d = byte_t'(rand_bits(8));
            @(posedge gmii_tx_clk);
            host_we_i   <= 1'b1;
            host_addr_i <= ram_addr_t'(a);
            host_data_i <= d;
            model_mem[a] = d;
        end
        @(posedge gmii_tx_clk);
        host_we_i <= 1'b0;
    endtask

    // Records the next frame and returns the idle cycles before it.
    task automatic capture_frame(output int idle);
        idle = 1;   // Sample that closed the previous frame.
        got_q.delete();
        @(negedge gmii_tx_clk);
        while (!gmii_tx_en_o) begin
            if (done_o) abort_run("done_o was high before the last frame ended");
            idle++;
            @(negedge gmii_tx_clk);
        end
        while (gmii_tx_en_o) begin
            if (done_o) abort_run("done_o was high before the last frame ended");
            got_q.push_back(gmii_txd_o);
            @(negedge gmii_tx_clk);
        end
    endtask

    task automatic run_transfer(input len_t len, input ram_addr_t addr);
        len_t      remain;
        len_t      plen;
        len_t      frames;
        ram_addr_t run_addr;
        int        idle;
        remain   = len;
        run_addr = addr;
        frames   = '0;
        @(posedge gmii_tx_clk);
        send_i    <= 1'b1;
        tx_len_i  <= len;
        tx_addr_i <= addr;
        while (remain != '0) begin
            plen = (remain > PKT_MAX_LEN) ? PKT_MAX_LEN : remain;
            build_frame(plen, run_addr);
            capture_frame(idle);
            if (frames != '0 && idle < IFG_CYCLES) abort_run("interframe gap too short");
            check_len(len_t'(got_q.size()), len_t'(exp_q.size()), "frame length");
            check_len({got_q[46], got_q[47]}, plen + 16'd8, "UDP length field");
            foreach (exp_q[i]) begin
                check_byte(got_q[i], exp_q[i], $sformatf("frame %0d byte %0d", frames, i));
            end
            remain   = remain - plen;
            run_addr = ram_addr_t'(run_addr + plen);
            frames   = frames + 1'b1;
        end
        while (!done_o) begin
            if (gmii_tx_en_o) abort_run("a frame appeared beyond the expected count");
            @(negedge gmii_tx_clk);
        end
        @(posedge gmii_tx_clk);
        send_i <= 1'b0;
        @(negedge gmii_tx_clk);
        if (!done_o) abort_run("done_o fell in the same cycle that send_i was released");
        while (done_o) begin
            if (gmii_tx_en_o) abort_run("a frame appeared while done_o was high");
            @(negedge gmii_tx_clk);
        end
    endtask

    always @(posedge gmii_tx_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) abort_run("timeout, the run exceeded its cycle limit");
    end

    initial begin
        rst         = 1'b1;
        send_i      = 1'b0;
        tx_len_i    = '0;
        tx_addr_i   = '0;
        host_we_i   = 1'b0;
        host_addr_i = '0;
        host_data_i = '0;
        cycle_limit = $size(model_mem) + 64;
        foreach (lens[t]) begin
            case (t)
                0, 4:    lens[t] = len_t'(1 + rand_bits(8) % 17);     // Padded.
                1:       lens[t] = PKT_MAX_LEN;
                2, 5:    lens[t] = len_t'(2801 + rand_bits(8) % 200);   // Three packets.
                default: lens[t] = len_t'(1 + rand_bits(12) % 3000);
            endcase
            addrs[t] = ram_addr_t'(rand_bits(12));
            cycle_limit += 3 * lens[t] + 100 * packet_count(lens[t]);
        end
        repeat (2) @(posedge gmii_tx_clk);
        rst <= 1'b0;
        fill_ram();
        foreach (lens[t]) begin
            run_transfer(lens[t], addrs[t]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* tx_segmenter.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_segmenter (
    input  wire                     gmii_tx_clk,
    input  wire                     rst,
    input  wire                     send_i,
    input  wire eth_pkg::len_t      tx_len_i,
    input  wire eth_pkg::ram_addr_t tx_addr_i,
    output logic                    done_o,
    output eth_pkg::wb_req_t        wb_req_o,
    input  wire eth_pkg::wb_rsp_t   wb_rsp_i,
    output logic                    pkt_req_o,
    output eth_pkg::len_t           pkt_len_o,
    output logic                    wr_en_o,
    output eth_pkg::byte_t          wr_data_o,
    input  wire                     pkt_end_i
);
    import eth_pkg::*;

    typedef enum logic [2:0] {
        WAIT,
        DOOR,
        MAKE,
        FETCH,
        REST,
        DONE
    } seg_state_t;

    seg_state_t state;
    len_t       remain;      // Bytes not yet assigned to a packet.
    len_t       fetch_cnt;
    ram_addr_t  rd_addr;

    // Wishbone master. stb is low in the ack cycle.
    always_comb begin
        wb_req_o.cyc = (state == FETCH);
        wb_req_o.stb = (state == FETCH) && !wb_rsp_i.ack;
        wb_req_o.adr = rd_addr;
    end

    assign done_o = (state == DONE);

    // ####################
    // Transfer FSM.
    always_ff @(posedge gmii_tx_clk or posedge rst) begin
        if (rst) begin
            state     <= WAIT;
            remain    <= '0;
            fetch_cnt <= '0;
            rd_addr   <= '0;
            pkt_req_o <= 1'b0;
            pkt_len_o <= '0;
            wr_en_o   <= 1'b0;
        end else begin
            pkt_req_o <= 1'b0;
            wr_en_o   <= 1'b0;
            case (state)
                WAIT: begin
                    if (send_i) begin
                        remain  <= tx_len_i;
                        rd_addr <= tx_addr_i;
                        state   <= DOOR;
                    end
                end
                DOOR: begin
                    state <= (remain == '0) ? DONE : MAKE;
                end
                MAKE: begin
                    if (remain > PKT_MAX_LEN) begin
                        pkt_len_o <= PKT_MAX_LEN;
                        remain    <= remain - PKT_MAX_LEN;
                    end else begin
                        pkt_len_o <= remain;   // Last packet.
                        remain    <= '0;
                    end
                    pkt_req_o <= 1'b1;
                    fetch_cnt <= '0;
                    state     <= FETCH;
                end
                FETCH: begin
                    if (wb_rsp_i.ack) begin
                        wr_en_o   <= 1'b1;
                        rd_addr   <= rd_addr + 1'b1;
                        fetch_cnt <= fetch_cnt + 1'b1;
                        if (fetch_cnt == pkt_len_o - 1'b1) begin
                            state <= REST;
                        end
                    end
                end
                REST: begin
                    if (pkt_end_i) begin
                        state <= DOOR;
                    end
                end
                DONE: begin
                    if (!send_i) begin
                        state <= WAIT;
                    end
                end
                default: state <= WAIT;
            endcase
        end
    end

    always_ff @(posedge gmii_tx_clk) begin
        if (wb_rsp_i.ack) begin
            wr_data_o <= wb_rsp_i.dat;
        end
    end

endmodule

`default_nettype wire

/* udp_framer.sv */
`timescale 1ns/100ps
`default_nettype none

module udp_framer (
    input  wire                  gmii_tx_clk,
    input  wire                  rst,
    input  wire                  pkt_req_i,
    input  wire eth_pkg::len_t   pkt_len_i,
    input  wire                  wr_en_i,
    input  wire eth_pkg::byte_t  wr_data_i,
    output logic                 pkt_end_o,
    output eth_pkg::frame_beat_t beat_o
);
    import eth_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        PREAMBLE,
        HEADER,
        PAYLOAD,
        GAP
    } frm_state_t;

    frm_state_t   state;
    len_t         pkt_len;
    len_t         pad_len;
    len_t         idx;        // Byte index within the current section.
    buf_addr_t    wr_ptr;
    buf_addr_t    rd_ptr;
    byte_t        rd_data;
    logic [31:0]  csum_acc;
    logic [335:0] hdr;
    byte_t        pkt_buf [2**$bits(buf_addr_t)];

    assign pad_len   = (pkt_len < MIN_PAYLOAD) ? MIN_PAYLOAD : pkt_len;
    assign rd_ptr    = (state == PAYLOAD) ? buf_addr_t'(idx + 1'b1) : '0;   // One ahead.
    assign pkt_end_o = (state == GAP) && (idx == len_t'(IFG_CYCLES + 3));

    // Ethernet, IPv4 and UDP headers, first byte at the top.
    assign hdr = {DST_MAC, SRC_MAC, 16'h0800,
                  16'h4500, pkt_len + 16'd28, 16'h0000, 16'h4000,
                  IP_TTL, 8'h11, ~csum_acc[15:0], SRC_IP, DST_IP,
                  UDP_SRC_PORT, UDP_DST_PORT, pkt_len + 16'd8, 16'h0000};

    always_ff @(posedge gmii_tx_clk) begin
        if (state == LOAD && wr_en_i) begin
            pkt_buf[wr_ptr] <= wr_data_i;
        end
        rd_data <= pkt_buf[rd_ptr];
    end

    // ####################
    // Sequencer.
    always_ff @(posedge gmii_tx_clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            pkt_len  <= '0;
            idx      <= '0;
            wr_ptr   <= '0;
            csum_acc <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pkt_req_i) begin
                        pkt_len  <= pkt_len_i;
                        wr_ptr   <= '0;
                        csum_acc <= 32'h4500 + 32'h4000 + {IP_TTL, 8'h11}
                                  + SRC_IP[31:16] + SRC_IP[15:0]
                                  + DST_IP[31:16] + DST_IP[15:0]
                                  + pkt_len_i + 32'd28;
                        state    <= LOAD;
                    end
                end
                LOAD: begin
                    // Fold carries back in.
                    csum_acc <= {16'h0000, csum_acc[15:0]} + {16'h0000, csum_acc[31:16]};
                    if (wr_en_i) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (len_t'(wr_ptr) == pkt_len - 1'b1) begin
                            idx   <= '0;
                            state <= PREAMBLE;
                        end
                    end
                end
                PREAMBLE: begin
                    idx <= (idx == 16'd7) ? '0 : idx + 1'b1;
                    if (idx == 16'd7) state <= HEADER;
                end
                HEADER: begin
                    idx <= (idx == 16'd41) ? '0 : idx + 1'b1;
                    if (idx == 16'd41) state <= PAYLOAD;
                end
                PAYLOAD: begin
                    idx <= (idx == pad_len - 1'b1) ? '0 : idx + 1'b1;
                    if (idx == pad_len - 1'b1) state <= GAP;
                end
                GAP: begin
                    idx <= pkt_end_o ? '0 : idx + 1'b1;   // FCS plus IFG.
                    if (pkt_end_o) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        beat_o = '0;
        case (state)
            PREAMBLE: begin
                beat_o.valid = 1'b1;
                beat_o.data  = (idx == 16'd7) ? 8'hD5 : 8'h55;   // SFD last.
            end
            HEADER: begin
                beat_o.valid = 1'b1;
                beat_o.calc  = 1'b1;
                beat_o.data  = hdr[(16'd41 - idx) * 8 +: 8];
            end
            PAYLOAD: begin
                beat_o.valid = 1'b1;
                beat_o.calc  = 1'b1;
                beat_o.last  = (idx == pad_len - 1'b1);
                beat_o.data  = (idx < pkt_len) ? rd_data : 8'h00;   // Zero padding.
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire
